// File: mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Data path and address width
`define MIPS_XLEN 32

// Instruction memory, in 32-bit words
`define MIPS_IMEM_DEPTH 64
`define MIPS_IMEM_AW $clog2(`MIPS_IMEM_DEPTH)

// Data memory, in 32-bit words
`define MIPS_DMEM_DEPTH 64
`define MIPS_DMEM_AW $clog2(`MIPS_DMEM_DEPTH)

// General purpose register file
`define MIPS_REG_COUNT 32
`define MIPS_REG_AW $clog2(`MIPS_REG_COUNT)

`endif

// File: mips_pkg.sv
`default_nettype none

package mips_pkg;

	// Primary opcode, instruction[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_BEQ   = 6'd4,
		OP_ADDI  = 6'd8,
		OP_LW    = 6'd35,
		OP_SW    = 6'd43
	} opcode_e;

	// R-type function code, instruction[5:0]
	typedef enum logic [5:0] {
		F_ADD = 6'd32,
		F_SUB = 6'd34,
		F_AND = 6'd36,
		F_OR  = 6'd37,
		F_SLT = 6'd42
	} funct_e;

	// Operation class from the main decoder
	typedef enum logic [1:0] {
		ALU_ADD   = 2'd0, // Address calc and addi
		ALU_SUB   = 2'd1, // beq compare
		ALU_FUNCT = 2'd2  // Look at funct
	} alu_op_e;

	// Classic MIPS ALU control encoding
	typedef enum logic [2:0] {
		ALUC_AND = 3'b000,
		ALUC_OR  = 3'b001,
		ALUC_ADD = 3'b010,
		ALUC_SUB = 3'b110,
		ALUC_SLT = 3'b111
	} alu_ctrl_e;

endpackage

`default_nettype wire

// File: instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module instruction_fetch (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      imem_we,
	input  wire [`MIPS_IMEM_AW-1:0]  imem_addr,
	input  wire [`MIPS_XLEN-1:0]     imem_wdata,
	input  wire                      pc_src,
	input  wire [`MIPS_XLEN-1:0]     branch_target,
	output logic [`MIPS_XLEN-1:0]    instruction,
	output logic [`MIPS_XLEN-1:0]    pc_plus4
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pc_seq;
	logic [`MIPS_XLEN-1:0] imem [`MIPS_IMEM_DEPTH];
	logic [`MIPS_IMEM_AW-1:0] fetch_idx;

	assign pc_seq    = pc + `MIPS_XLEN'd4;
	assign fetch_idx = pc[`MIPS_IMEM_AW+1:2]; // Word index, wraps at depth

	// Program load port
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_src) begin
			pc <= branch_target; // Taken beq from MEM stage
		end else begin
			pc <= pc_seq;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (reset) begin
			instruction <= '0;
			pc_plus4    <= '0;
		end else begin
			instruction <= imem[fetch_idx];
			pc_plus4    <= pc_seq;
		end
	end

endmodule

`default_nettype wire

// File: instruction_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module instruction_decode (
	input  wire                       clk,
	input  wire                       reset,
	input  wire [`MIPS_XLEN-1:0]      instruction,
	input  wire [`MIPS_XLEN-1:0]      pc_plus4,
	input  wire                       wb_en,
	input  wire [`MIPS_REG_AW-1:0]    wb_reg,
	input  wire [`MIPS_XLEN-1:0]      wb_data,
	output logic                      reg_write_id_ex,
	output logic                      mem_to_reg_id_ex,
	output logic                      mem_read_id_ex,
	output logic                      mem_write_id_ex,
	output logic                      branch_id_ex,
	output logic                      alu_src_id_ex,
	output logic                      reg_dst_id_ex,
	output mips_pkg::alu_op_e         alu_op_id_ex,
	output logic [`MIPS_XLEN-1:0]     read_data_1_id_ex,
	output logic [`MIPS_XLEN-1:0]     read_data_2_id_ex,
	output logic [`MIPS_XLEN-1:0]     imm_ext_id_ex,
	output logic [`MIPS_REG_AW-1:0]   rt_id_ex,
	output logic [`MIPS_REG_AW-1:0]   rd_id_ex,
	output logic [`MIPS_XLEN-1:0]     pc_plus4_id_ex
);

	mips_pkg::opcode_e opcode;
	mips_pkg::alu_op_e alu_op;
	logic reg_write, mem_to_reg, mem_read, mem_write, branch, alu_src, reg_dst;
	logic [`MIPS_REG_AW-1:0] rs, rt, rd, dest;
	logic [`MIPS_XLEN-1:0] read_data_1, read_data_2, imm_ext;
	logic [`MIPS_XLEN-1:0] regs [`MIPS_REG_COUNT];

	assign opcode = mips_pkg::opcode_e'(instruction[31:26]);
	assign rs     = instruction[25:21];
	assign rt     = instruction[20:16];
	assign rd     = instruction[15:11];

	// Main control decoder
	always_comb begin
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		branch     = 1'b0;
		alu_src    = 1'b0;
		reg_dst    = 1'b0;
		alu_op     = mips_pkg::ALU_ADD;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				reg_write = 1'b1;
				reg_dst   = 1'b1; // Destination in rd
				alu_op    = mips_pkg::ALU_FUNCT;
			end
			mips_pkg::OP_ADDI: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OP_LW: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
				mem_read   = 1'b1;
				alu_src    = 1'b1;
			end
			mips_pkg::OP_SW: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				branch = 1'b1;
				alu_op = mips_pkg::ALU_SUB;
			end
			default: ; // Unknown opcode acts as nop
		endcase
	end

	assign dest    = reg_dst ? rd : rt;
	assign imm_ext = {{(`MIPS_XLEN-16){instruction[15]}}, instruction[15:0]};

	// Register file, written from MEM/WB
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en && wb_reg != '0) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write-through reads, r0 hard zero
	always_comb begin
		if (rs == '0)
			read_data_1 = '0;
		else if (wb_en && wb_reg == rs)
			read_data_1 = wb_data;
		else
			read_data_1 = regs[rs];
		if (rt == '0)
			read_data_2 = '0;
		else if (wb_en && wb_reg == rt)
			read_data_2 = wb_data;
		else
			read_data_2 = regs[rt];
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_id_ex   <= 1'b0;
			mem_to_reg_id_ex  <= 1'b0;
			mem_read_id_ex    <= 1'b0;
			mem_write_id_ex   <= 1'b0;
			branch_id_ex      <= 1'b0;
			alu_src_id_ex     <= 1'b0;
			reg_dst_id_ex     <= 1'b0;
			alu_op_id_ex      <= mips_pkg::ALU_ADD;
			read_data_1_id_ex <= '0;
			read_data_2_id_ex <= '0;
			imm_ext_id_ex     <= '0;
			rt_id_ex          <= '0;
			rd_id_ex          <= '0;
			pc_plus4_id_ex    <= '0;
		end else begin
			reg_write_id_ex   <= reg_write && dest != '0; // No writes to r0
			mem_to_reg_id_ex  <= mem_to_reg;
			mem_read_id_ex    <= mem_read;
			mem_write_id_ex   <= mem_write;
			branch_id_ex      <= branch;
			alu_src_id_ex     <= alu_src;
			reg_dst_id_ex     <= reg_dst;
			alu_op_id_ex      <= alu_op;
			read_data_1_id_ex <= read_data_1;
			read_data_2_id_ex <= read_data_2;
			imm_ext_id_ex     <= imm_ext;
			rt_id_ex          <= rt;
			rd_id_ex          <= rd;
			pc_plus4_id_ex    <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

// File: execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module execute (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       reg_write_id_ex,
	input  wire                       mem_to_reg_id_ex,
	input  wire                       mem_read_id_ex,
	input  wire                       mem_write_id_ex,
	input  wire                       branch_id_ex,
	input  wire                       alu_src_id_ex,
	input  wire                       reg_dst_id_ex,
	input  mips_pkg::alu_op_e         alu_op_id_ex,
	input  wire [`MIPS_XLEN-1:0]      read_data_1_id_ex,
	input  wire [`MIPS_XLEN-1:0]      read_data_2_id_ex,
	input  wire [`MIPS_XLEN-1:0]      imm_ext_id_ex,
	input  wire [`MIPS_REG_AW-1:0]    rt_id_ex,
	input  wire [`MIPS_REG_AW-1:0]    rd_id_ex,
	input  wire [`MIPS_XLEN-1:0]      pc_plus4_id_ex,
	output logic                      reg_write_ex_mem,
	output logic                      mem_to_reg_ex_mem,
	output logic                      mem_read_ex_mem,
	output logic                      mem_write_ex_mem,
	output logic                      branch_ex_mem,
	output logic [`MIPS_XLEN-1:0]     alu_result_ex_mem,
	output logic                      zero_ex_mem,
	output logic [`MIPS_XLEN-1:0]     write_data_ex_mem,
	output logic [`MIPS_REG_AW-1:0]   write_reg_ex_mem,
	output logic [`MIPS_XLEN-1:0]     branch_target_ex_mem
);

	mips_pkg::alu_ctrl_e alu_ctrl;
	mips_pkg::funct_e    funct;
	logic [`MIPS_XLEN-1:0] operand_b, alu_result, branch_target;
	logic [`MIPS_REG_AW-1:0] write_reg;

	assign funct = mips_pkg::funct_e'(imm_ext_id_ex[5:0]); // Low bits of the immediate

	// ALU control
	always_comb begin
		case (alu_op_id_ex)
			mips_pkg::ALU_SUB: alu_ctrl = mips_pkg::ALUC_SUB;
			mips_pkg::ALU_FUNCT: begin
				case (funct)
					mips_pkg::F_SUB: alu_ctrl = mips_pkg::ALUC_SUB;
					mips_pkg::F_AND: alu_ctrl = mips_pkg::ALUC_AND;
					mips_pkg::F_OR:  alu_ctrl = mips_pkg::ALUC_OR;
					mips_pkg::F_SLT: alu_ctrl = mips_pkg::ALUC_SLT;
					default:         alu_ctrl = mips_pkg::ALUC_ADD;
				endcase
			end
			default: alu_ctrl = mips_pkg::ALUC_ADD;
		endcase
	end

	assign operand_b = alu_src_id_ex ? imm_ext_id_ex : read_data_2_id_ex;

	always_comb begin
		case (alu_ctrl)
			mips_pkg::ALUC_AND: alu_result = read_data_1_id_ex & operand_b;
			mips_pkg::ALUC_OR:  alu_result = read_data_1_id_ex | operand_b;
			mips_pkg::ALUC_SUB: alu_result = read_data_1_id_ex - operand_b;
			mips_pkg::ALUC_SLT: alu_result = {{(`MIPS_XLEN-1){1'b0}},
				$signed(read_data_1_id_ex) < $signed(operand_b)}; // Signed compare
			default:            alu_result = read_data_1_id_ex + operand_b;
		endcase
	end

	assign write_reg     = reg_dst_id_ex ? rd_id_ex : rt_id_ex;
	assign branch_target = pc_plus4_id_ex + {imm_ext_id_ex[`MIPS_XLEN-3:0], 2'b00};

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_ex_mem     <= 1'b0;
			mem_to_reg_ex_mem    <= 1'b0;
			mem_read_ex_mem      <= 1'b0;
			mem_write_ex_mem     <= 1'b0;
			branch_ex_mem        <= 1'b0;
			alu_result_ex_mem    <= '0;
			zero_ex_mem          <= 1'b0;
			write_data_ex_mem    <= '0;
			write_reg_ex_mem     <= '0;
			branch_target_ex_mem <= '0;
		end else begin
			reg_write_ex_mem     <= reg_write_id_ex;
			mem_to_reg_ex_mem    <= mem_to_reg_id_ex;
			mem_read_ex_mem      <= mem_read_id_ex;
			mem_write_ex_mem     <= mem_write_id_ex;
			branch_ex_mem        <= branch_id_ex;
			alu_result_ex_mem    <= alu_result;
			zero_ex_mem          <= alu_result == '0;
			write_data_ex_mem    <= read_data_2_id_ex; // Store data is rt
			write_reg_ex_mem     <= write_reg;
			branch_target_ex_mem <= branch_target;
		end
	end

endmodule

`default_nettype wire

// File: memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module memory_writeback (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       reg_write_ex_mem,
	input  wire                       mem_to_reg_ex_mem,
	input  wire                       mem_read_ex_mem,
	input  wire                       mem_write_ex_mem,
	input  wire                       branch_ex_mem,
	input  wire [`MIPS_XLEN-1:0]      alu_result_ex_mem,
	input  wire                       zero_ex_mem,
	input  wire [`MIPS_XLEN-1:0]      write_data_ex_mem,
	input  wire [`MIPS_REG_AW-1:0]    write_reg_ex_mem,
	output logic                      pc_src,
	output logic                      wb_en,
	output logic [`MIPS_REG_AW-1:0]   wb_reg,
	output logic [`MIPS_XLEN-1:0]     wb_data,
	output logic                      st_en,
	output logic [`MIPS_XLEN-1:0]     st_addr,
	output logic [`MIPS_XLEN-1:0]     st_data
);

	logic [`MIPS_XLEN-1:0] dmem [`MIPS_DMEM_DEPTH];
	logic [`MIPS_DMEM_AW-1:0] dmem_idx;
	logic [`MIPS_XLEN-1:0] load_data;
	logic reg_write_mem_wb, mem_to_reg_mem_wb;
	logic [`MIPS_XLEN-1:0] load_data_mem_wb, alu_result_mem_wb;
	logic [`MIPS_REG_AW-1:0] write_reg_mem_wb;

	assign dmem_idx = alu_result_ex_mem[`MIPS_DMEM_AW+1:2]; // Word address, wraps

	always_ff @(posedge clk) begin
		if (mem_write_ex_mem) begin
			dmem[dmem_idx] <= write_data_ex_mem;
		end
	end

	assign load_data = mem_read_ex_mem ? dmem[dmem_idx] : '0;

	assign pc_src  = branch_ex_mem & zero_ex_mem; // beq taken
	assign st_en   = mem_write_ex_mem;
	assign st_addr = alu_result_ex_mem;
	assign st_data = write_data_ex_mem;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_mem_wb  <= 1'b0;
			mem_to_reg_mem_wb <= 1'b0;
			load_data_mem_wb  <= '0;
			alu_result_mem_wb <= '0;
			write_reg_mem_wb  <= '0;
		end else begin
			reg_write_mem_wb  <= reg_write_ex_mem;
			mem_to_reg_mem_wb <= mem_to_reg_ex_mem;
			load_data_mem_wb  <= load_data;
			alu_result_mem_wb <= alu_result_ex_mem;
			write_reg_mem_wb  <= write_reg_ex_mem;
		end
	end

	// Write-back select
	assign wb_en   = reg_write_mem_wb;
	assign wb_reg  = write_reg_mem_wb;
	assign wb_data = mem_to_reg_mem_wb ? load_data_mem_wb : alu_result_mem_wb;

endmodule

`default_nettype wire

// File: mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_pipeline (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       imem_we,
	input  wire [`MIPS_IMEM_AW-1:0]   imem_addr,
	input  wire [`MIPS_XLEN-1:0]      imem_wdata,
	output logic                      wb_en,
	output logic [`MIPS_REG_AW-1:0]   wb_reg,
	output logic [`MIPS_XLEN-1:0]     wb_data,
	output logic                      st_en,
	output logic [`MIPS_XLEN-1:0]     st_addr,
	output logic [`MIPS_XLEN-1:0]     st_data
);

	// IF/ID
	logic [`MIPS_XLEN-1:0] instruction, pc_plus4;

	// ID/EX
	logic reg_write_id_ex, mem_to_reg_id_ex, mem_read_id_ex, mem_write_id_ex;
	logic branch_id_ex, alu_src_id_ex, reg_dst_id_ex;
	mips_pkg::alu_op_e alu_op_id_ex;
	logic [`MIPS_XLEN-1:0] read_data_1_id_ex, read_data_2_id_ex;
	logic [`MIPS_XLEN-1:0] imm_ext_id_ex, pc_plus4_id_ex;
	logic [`MIPS_REG_AW-1:0] rt_id_ex, rd_id_ex;

	// EX/MEM
	logic reg_write_ex_mem, mem_to_reg_ex_mem, mem_read_ex_mem, mem_write_ex_mem;
	logic branch_ex_mem, zero_ex_mem;
	logic [`MIPS_XLEN-1:0] alu_result_ex_mem, write_data_ex_mem, branch_target_ex_mem;
	logic [`MIPS_REG_AW-1:0] write_reg_ex_mem;

	logic pc_src; // Redirect from MEM stage

	instruction_fetch u_if (
		.clk, .reset, .imem_we, .imem_addr, .imem_wdata, .pc_src,
		.branch_target (branch_target_ex_mem),
		.instruction, .pc_plus4
	);

	instruction_decode u_id (
		.clk, .reset, .instruction, .pc_plus4, .wb_en, .wb_reg, .wb_data,
		.reg_write_id_ex, .mem_to_reg_id_ex, .mem_read_id_ex, .mem_write_id_ex,
		.branch_id_ex, .alu_src_id_ex, .reg_dst_id_ex, .alu_op_id_ex,
		.read_data_1_id_ex, .read_data_2_id_ex, .imm_ext_id_ex,
		.rt_id_ex, .rd_id_ex, .pc_plus4_id_ex
	);

	execute u_ex (
		.clk, .reset,
		.reg_write_id_ex, .mem_to_reg_id_ex, .mem_read_id_ex, .mem_write_id_ex,
		.branch_id_ex, .alu_src_id_ex, .reg_dst_id_ex, .alu_op_id_ex,
		.read_data_1_id_ex, .read_data_2_id_ex, .imm_ext_id_ex,
		.rt_id_ex, .rd_id_ex, .pc_plus4_id_ex,
		.reg_write_ex_mem, .mem_to_reg_ex_mem, .mem_read_ex_mem, .mem_write_ex_mem,
		.branch_ex_mem, .alu_result_ex_mem, .zero_ex_mem, .write_data_ex_mem,
		.write_reg_ex_mem, .branch_target_ex_mem
	);

	memory_writeback u_mem (
		.clk, .reset,
		.reg_write_ex_mem, .mem_to_reg_ex_mem, .mem_read_ex_mem, .mem_write_ex_mem,
		.branch_ex_mem, .alu_result_ex_mem, .zero_ex_mem, .write_data_ex_mem,
		.write_reg_ex_mem,
		.pc_src, .wb_en, .wb_reg, .wb_data, .st_en, .st_addr, .st_data
	);

endmodule

`default_nettype wire

// File: tb_mips_model.svh
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

localparam int MODEL_SLOTS = 160;

function automatic void note_event(input bit kind, input logic [31:0] a, input logic [31:0] b);
	exp_kind.push_back(kind);
	exp_a.push_back(a);
	exp_b.push_back(b);
endfunction

// Runs the loaded program one issue slot at a time, no forwarding or flush
function automatic void predict_trace();
	logic [31:0] regs [32];
	logic        w_en [MODEL_SLOTS];
	logic [4:0]  w_reg [MODEL_SLOTS];
	logic [31:0] w_val [MODEL_SLOTS];
	logic        redir [MODEL_SLOTS+4];
	logic [31:0] redir_pc [MODEL_SLOTS+4];
	logic [31:0] pc, instr, a, b, imm, res, addr;
	logic [4:0]  rs, rt, rd;
	for (int i = 0; i < 32; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < MODEL_SLOTS + 4; i++) begin
		redir[i] = 1'b0;
		redir_pc[i] = '0;
		if (i < MODEL_SLOTS) begin
			w_en[i] = 1'b0;
			w_reg[i] = '0;
			w_val[i] = '0;
		end
	end
	pc = '0;
	for (int s = 0; s < MODEL_SLOTS; s++) begin
		if (s >= 3 && w_en[s-3]) begin
			regs[w_reg[s-3]] = w_val[s-3]; // Producer three slots back becomes visible
		end
		if (s > 0) begin
			pc = redir[s] ? redir_pc[s] : pc + 32'd4;
		end
		instr = prog[pc[IAW+1:2]];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		a = regs[rs];
		b = regs[rt];
		imm = {{16{instr[15]}}, instr[15:0]};
		addr = a + imm;
		case (instr[31:26])
			mips_pkg::OP_RTYPE: begin
				case (instr[5:0])
					mips_pkg::F_SUB: res = a - b;
					mips_pkg::F_AND: res = a & b;
					mips_pkg::F_OR:  res = a | b;
					mips_pkg::F_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:         res = a + b;
				endcase
				w_en[s] = rd != 5'd0;
				w_reg[s] = rd;
				w_val[s] = res;
			end
			mips_pkg::OP_ADDI: begin
				w_en[s] = rt != 5'd0;
				w_reg[s] = rt;
				w_val[s] = a + imm;
			end
			mips_pkg::OP_LW: begin
				w_en[s] = rt != 5'd0;
				w_reg[s] = rt;
				w_val[s] = model_dmem[addr[DAW+1:2]];
			end
			mips_pkg::OP_SW: begin
				model_dmem[addr[DAW+1:2]] = b;
				note_event(1'b1, addr, b);
			end
			mips_pkg::OP_BEQ: begin
				if (a == b) begin
					redir[s+4] = 1'b1; // Three delay slots
					redir_pc[s+4] = pc + 32'd4 + {imm[29:0], 2'b00};
				end
			end
			default: ;
		endcase
		if (w_en[s]) begin
			note_event(1'b0, 32'(w_reg[s]), w_val[s]);
		end
	end
endfunction

`endif

// File: tb_mips_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module tb_mips_pipeline;

	localparam int IAW = `MIPS_IMEM_AW;
	localparam int DAW = `MIPS_DMEM_AW;
	localparam int NUM_TESTS = 5;
	localparam int WAIT_LIMIT = 4 * `MIPS_IMEM_DEPTH;
	localparam int TIMEOUT_CYCLES = 8 * `MIPS_IMEM_DEPTH * NUM_TESTS + 20 * NUM_TESTS;

	logic clk, reset, imem_we;
	logic [IAW-1:0] imem_addr;
	logic [31:0] imem_wdata;
	logic wb_en, st_en;
	logic [4:0] wb_reg;
	logic [31:0] wb_data, st_addr, st_data;

	logic [31:0] prog [`MIPS_IMEM_DEPTH];
	logic [31:0] model_dmem [`MIPS_DMEM_DEPTH];
	int prog_len;
	bit exp_kind [$]; // 0 for write-back and 1 for store
	logic [31:0] exp_a [$];
	logic [31:0] exp_b [$];
	int errors, failed_tests, tests_run, cycle_count;
	bit monitor_on;
	integer seed;

	`include "tb_mips_model.svh"

	mips_pipeline u_dut (
		.clk, .reset, .imem_we, .imem_addr, .imem_wdata,
		.wb_en, .wb_reg, .wb_data, .st_en, .st_addr, .st_data
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic match_event(input bit kind, input logic [31:0] a, input logic [31:0] b);
		bit ek;
		logic [31:0] ea, eb;
		if (exp_kind.size() == 0) begin
			$display("Unexpected %s at %0t when no more events were expected",
				kind ? "store" : "write-back", $time);
			errors++;
		end else begin
			ek = exp_kind.pop_front();
			ea = exp_a.pop_front();
			eb = exp_b.pop_front();
			if (ek != kind) begin
				$display("Got a %s at %0t where a %s was expected",
					kind ? "store" : "write-back", $time, ek ? "store" : "write-back");
				errors++;
			end else begin
				check_value(kind ? "st_addr" : "wb_reg", a, ea);
				check_value(kind ? "st_data" : "wb_data", b, eb);
			end
		end
	endtask

	// Outputs settle after the rising edge so sampling is on the falling one
	always @(negedge clk) begin
		if (monitor_on) begin
			if (wb_en)
				match_event(1'b0, 32'(wb_reg), wb_data); // Older instruction first
			if (st_en)
				match_event(1'b1, st_addr, st_data);
		end
	end

	function automatic logic [31:0] r_type(input logic [5:0] funct, input int rd,
		input int rs, input int rt);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input int rt,
		input int rs, input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	task automatic clear_program();
		for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
			prog[i] = '0; // Word zero is a nop
		end
		prog_len = 0;
	endtask

	task automatic add_word(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Self loop on r0 plus its delay slots
	task automatic add_end_loop();
		add_word(i_type(mips_pkg::OP_BEQ, 0, 0, -1));
		repeat (3) add_word(32'd0);
	endtask

	task automatic rand_below(input int n, output int v);
		v = int'($unsigned($random(seed)) % n);
	endtask

	task automatic run_program(input string name);
		int errs_before;
		int waited;
		errs_before = errors;
		tests_run++;
		@(negedge clk);
		monitor_on = 1'b0;
		reset = 1'b1;
		for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
			imem_we = 1'b1;
			imem_addr = IAW'(i);
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		repeat (2) @(negedge clk);
		exp_kind.delete();
		exp_a.delete();
		exp_b.delete();
		predict_trace();
		reset = 1'b0;
		monitor_on = 1'b1;
		waited = 0;
		while (exp_kind.size() > 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		repeat (12) @(negedge clk); // Catch stray events
		@(posedge clk);
		monitor_on = 1'b0;
		if (exp_kind.size() > 0) begin
			$display("%0d expected events never appeared in %s", exp_kind.size(), name);
			errors++;
		end
		if (errors != errs_before)
			failed_tests++;
		$display("test %s: %s, %0d errors", name, (errors == errs_before) ? "ok" : "failed",
			errors - errs_before);
	endtask

	initial begin
		int kind, r1, r2, r3, v;
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_wdata = '0;
		monitor_on = 1'b0;
		errors = 0;
		failed_tests = 0;
		tests_run = 0;
		cycle_count = 0;
		seed = 32'h44a8;
		for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
			model_dmem[i] = 'x;
		end

		clear_program();
		add_word(i_type(mips_pkg::OP_ADDI, 1, 0, 5));
		add_word(i_type(mips_pkg::OP_ADDI, 2, 0, -3));
		add_word(i_type(mips_pkg::OP_ADDI, 3, 0, 'h7f));
		add_word(32'd0);
		add_word(r_type(mips_pkg::F_ADD, 4, 1, 2));
		add_word(r_type(mips_pkg::F_SUB, 5, 1, 2));
		add_word(r_type(mips_pkg::F_AND, 6, 1, 3));
		add_word(r_type(mips_pkg::F_OR, 7, 2, 3));
		add_word(r_type(mips_pkg::F_SLT, 8, 2, 1));
		add_word(r_type(mips_pkg::F_SLT, 9, 1, 2));
		add_word(r_type(mips_pkg::F_ADD, 0, 1, 1)); // r0 writes are dropped
		add_word(i_type(mips_pkg::OP_ADDI, 0, 1, 9));
		add_end_loop();
		run_program("alu");

		clear_program();
		add_word(i_type(mips_pkg::OP_ADDI, 1, 0, 'h1234));
		add_word(i_type(mips_pkg::OP_ADDI, 2, 0, -100));
		add_word(i_type(mips_pkg::OP_ADDI, 3, 0, 4));
		add_word(32'd0);
		add_word(i_type(mips_pkg::OP_SW, 1, 0, 8));
		add_word(i_type(mips_pkg::OP_SW, 2, 0, 12));
		add_word(32'd0);
		add_word(i_type(mips_pkg::OP_LW, 4, 3, 4));
		add_word(i_type(mips_pkg::OP_LW, 5, 0, 12));
		add_word(i_type(mips_pkg::OP_LW, 6, 0, 8));
		add_end_loop();
		run_program("store_load");

		clear_program();
		add_word(i_type(mips_pkg::OP_ADDI, 1, 0, 10));
		add_word(i_type(mips_pkg::OP_ADDI, 1, 1, 1)); // Distance one
		add_word(i_type(mips_pkg::OP_ADDI, 2, 1, 2)); // Distances one and two
		add_word(r_type(mips_pkg::F_ADD, 3, 1, 1));
		add_word(r_type(mips_pkg::F_SUB, 4, 1, 2));
		add_word(r_type(mips_pkg::F_OR, 5, 2, 3));
		add_end_loop();
		run_program("stale_reads");

		clear_program();
		add_word(i_type(mips_pkg::OP_ADDI, 1, 0, 7));
		add_word(i_type(mips_pkg::OP_ADDI, 2, 0, 7));
		add_word(32'd0);
		add_word(32'd0);
		add_word(i_type(mips_pkg::OP_BEQ, 2, 1, 5)); // Taken and lands on word 10
		add_word(i_type(mips_pkg::OP_ADDI, 3, 0, 1));
		add_word(i_type(mips_pkg::OP_ADDI, 4, 0, 2));
		add_word(i_type(mips_pkg::OP_ADDI, 5, 0, 3));
		add_word(i_type(mips_pkg::OP_ADDI, 6, 0, 4));
		add_word(i_type(mips_pkg::OP_ADDI, 7, 0, 5));
		add_word(i_type(mips_pkg::OP_BEQ, 3, 1, 2)); // Not taken
		add_word(i_type(mips_pkg::OP_ADDI, 8, 0, 6));
		add_word(i_type(mips_pkg::OP_ADDI, 9, 0, 8));
		add_word(i_type(mips_pkg::OP_ADDI, 10, 0, 9));
		add_end_loop();
		run_program("branch");

		clear_program();
		for (int k = 1; k <= 8; k++) begin
			rand_below(65536, v);
			add_word(i_type(mips_pkg::OP_ADDI, k, 0, v));
		end
		for (int k = 1; k <= 8; k++) begin
			add_word(i_type(mips_pkg::OP_SW, k, 0, (k - 1) * 4)); // Seeds words 0 to 7
		end
		for (int n = 0; n < 40; n++) begin
			rand_below(5, kind);
			rand_below(12, r1);
			rand_below(12, r2);
			rand_below(12, r3);
			case (kind)
				0: begin
					rand_below(5, v);
					case (v)
						0: add_word(r_type(mips_pkg::F_ADD, r1, r2, r3));
						1: add_word(r_type(mips_pkg::F_SUB, r1, r2, r3));
						2: add_word(r_type(mips_pkg::F_AND, r1, r2, r3));
						3: add_word(r_type(mips_pkg::F_OR, r1, r2, r3));
						default: add_word(r_type(mips_pkg::F_SLT, r1, r2, r3));
					endcase
				end
				1: begin
					rand_below(65536, v);
					add_word(i_type(mips_pkg::OP_ADDI, r1, r2, v));
				end
				2: begin
					rand_below(8, v);
					add_word(i_type(mips_pkg::OP_LW, r1, 0, v * 4));
				end
				3: begin
					rand_below(8, v);
					add_word(i_type(mips_pkg::OP_SW, r1, 0, v * 4));
				end
				default: begin
					rand_below(6, v);
					if (prog_len + 1 + v > 56)
						v = 56 - prog_len - 1; // Never past the end loop
					add_word(i_type(mips_pkg::OP_BEQ, r1 % 4, r2 % 4, v));
				end
			endcase
		end
		add_end_loop();
		run_program("random");

		$display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
mips_pkg.sv
instruction_fetch.sv
instruction_decode.sv
execute.sv
memory_writeback.sv
mips_pipeline.sv
tb_mips_pipeline.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_mips_pipeline -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q '^\*\*\* PASSED \*\*\*$'; then
	exit 0
fi
exit 1
